//--- design/redmule_pkg.sv
package redmule_pkg;

  // Width of one matrix element and of every accumulation result
  localparam int unsigned ELEM_W = 16;

  // Width of the column count and the column counters
  localparam int unsigned COUNT_W = 8;

  // Job sequencing states of the scheduler
  typedef enum logic [1:0] {
    SCHED_IDLE,
    SCHED_LOAD_X,
    SCHED_COMPUTE,
    SCHED_DRAIN
  } sched_state_e;

endpackage : redmule_pkg

//--- design/redmule_scheduler.sv
`timescale 1ns/10ps

module redmule_scheduler #(
  parameter int unsigned Width      = 4,
  parameter int unsigned ZFifoDepth = 4
)(
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            start_i,
  input  logic [redmule_pkg::COUNT_W-1:0] n_cols_i,
  input  logic                            x_valid_i,
  input  logic                            x_full_i,
  input  logic                            w_valid_i,
  input  logic                            y_valid_i,
  input  logic                            z_pop_i,
  output logic                            x_load_o,
  output logic                            issue_o,
  output logic                            busy_o,
  output logic                            done_o
);

  localparam int unsigned RowCntW = $clog2(Width + 1);
  localparam int unsigned CreditW = $clog2(ZFifoDepth + 1);

  redmule_pkg::sched_state_e state_q, state_d;

  logic [redmule_pkg::COUNT_W-1:0] n_cols_q;
  logic [redmule_pkg::COUNT_W-1:0] issued_q;
  logic [redmule_pkg::COUNT_W-1:0] popped_q;
  logic [RowCntW-1:0]              x_rows_q;
  logic [CreditW-1:0]              credits_q;
  logic                            start_ok;
  logic                            cols_left;
  logic                            last_issue;
  logic                            all_popped;

  // Start is only honoured between jobs
  assign start_ok = start_i && (state_q == redmule_pkg::SCHED_IDLE);

  // Never ask for more rows than one tile holds
  assign x_load_o = (state_q == redmule_pkg::SCHED_LOAD_X) && x_valid_i &&
                    (x_rows_q != RowCntW'(Width));

  assign cols_left = (issued_q != n_cols_q);

  // A pair is taken only when both halves are there and the Z FIFO has room
  assign issue_o = (state_q == redmule_pkg::SCHED_COMPUTE) && cols_left &&
                   (credits_q != '0) && w_valid_i && y_valid_i;

  assign last_issue = issue_o && (issued_q == n_cols_q - redmule_pkg::COUNT_W'(1));
  assign all_popped = (popped_q == n_cols_q);

  assign busy_o = (state_q != redmule_pkg::SCHED_IDLE);
  assign done_o = (state_q == redmule_pkg::SCHED_DRAIN) && all_popped;

  always_comb begin
    state_d = state_q;
    case (state_q)
      redmule_pkg::SCHED_IDLE: begin
        if (start_i) begin
          state_d = redmule_pkg::SCHED_LOAD_X;
        end
      end
      redmule_pkg::SCHED_LOAD_X: begin
        if (x_full_i) begin
          state_d = redmule_pkg::SCHED_COMPUTE;
        end
      end
      redmule_pkg::SCHED_COMPUTE: begin
        if (last_issue) begin
          state_d = redmule_pkg::SCHED_DRAIN;
        end
      end
      redmule_pkg::SCHED_DRAIN: begin
        // Wait for the last Z column to leave the FIFO
        if (all_popped) begin
          state_d = redmule_pkg::SCHED_IDLE;
        end
      end
      default: begin
        state_d = redmule_pkg::SCHED_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q  <= redmule_pkg::SCHED_IDLE;
      n_cols_q <= '0;
      issued_q <= '0;
      popped_q <= '0;
      x_rows_q <= '0;
    end else begin
      state_q <= state_d;
      if (start_ok) begin
        n_cols_q <= n_cols_i;
        issued_q <= '0;
        popped_q <= '0;
        x_rows_q <= '0;
      end else begin
        if (x_load_o) begin
          x_rows_q <= x_rows_q + RowCntW'(1);
        end
        if (issue_o) begin
          issued_q <= issued_q + redmule_pkg::COUNT_W'(1);
        end
        if (z_pop_i) begin
          popped_q <= popped_q + redmule_pkg::COUNT_W'(1);
        end
      end
    end
  end

  // One credit per free Z FIFO entry
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_q <= CreditW'(ZFifoDepth);
    end else if (issue_o && !z_pop_i) begin
      credits_q <= credits_q - CreditW'(1);
    end else if (z_pop_i && !issue_o) begin
      credits_q <= credits_q + CreditW'(1);
    end
  end

endmodule : redmule_scheduler

//--- design/redmule_x_buffer.sv
`timescale 1ns/10ps

module redmule_x_buffer #(
  parameter int unsigned Width  = 4,
  parameter int unsigned Height = 4
)(
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  input  logic                                              start_i,
  input  logic                                              load_i,
  input  logic [Height-1:0][redmule_pkg::ELEM_W-1:0]        row_i,
  output logic [Width-1:0][Height-1:0][redmule_pkg::ELEM_W-1:0] x_tile_o,
  output logic                                              full_o
);

  localparam int unsigned RowCntW = $clog2(Width + 1);

  logic [RowCntW-1:0]                                  row_cnt_q;
  logic [Width-1:0][Height-1:0][redmule_pkg::ELEM_W-1:0] tile_q;
  logic                                                write_row;

  assign full_o    = (row_cnt_q == RowCntW'(Width));
  assign write_row = load_i && !full_o;

  // A new job restarts the row count once the previous tile is complete
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      row_cnt_q <= '0;
    end else if (start_i && full_o) begin
      row_cnt_q <= '0;
    end else if (write_row) begin
      row_cnt_q <= row_cnt_q + RowCntW'(1);
    end
  end

  // Rows land in the cycle they are accepted
  always_ff @(posedge clk_i) begin
    if (write_row) begin
      tile_q[row_cnt_q] <= row_i;
    end
  end

  assign x_tile_o = tile_q;

endmodule : redmule_x_buffer

//--- design/redmule_engine.sv
`timescale 1ns/10ps

module redmule_engine #(
  parameter int unsigned Width       = 4,
  parameter int unsigned Height      = 4,
  parameter int unsigned NumPipeRegs = 2
)(
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  input  logic                                              issue_i,
  input  logic [Width-1:0][Height-1:0][redmule_pkg::ELEM_W-1:0] x_tile_i,
  input  logic [Height-1:0][redmule_pkg::ELEM_W-1:0]        w_col_i,
  input  logic [Width-1:0][redmule_pkg::ELEM_W-1:0]         y_col_i,
  output logic                                              z_push_o,
  output logic [Width-1:0][redmule_pkg::ELEM_W-1:0]         z_col_o
);

  logic [Width-1:0][redmule_pkg::ELEM_W-1:0]                 mac_d;
  logic [NumPipeRegs:0][Width-1:0][redmule_pkg::ELEM_W-1:0]  stage_data_q;
  logic [NumPipeRegs:0]                                      stage_valid_q;

  // One dot product per row, seeded with the Y bias
  // Sums wrap at ELEM_W bits
  always_comb begin
    logic [redmule_pkg::ELEM_W-1:0] acc;
    for (int r = 0; r < Width; r++) begin
      acc = y_col_i[r];
      for (int h = 0; h < Height; h++) begin
        acc = acc + x_tile_i[r][h] * w_col_i[h];
      end
      mac_d[r] = acc;
    end
  end

  // Valid chain, each stage may carry its own column
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stage_valid_q <= '0;
    end else begin
      stage_valid_q[0] <= issue_i;
      for (int i = 1; i <= NumPipeRegs; i++) begin
        stage_valid_q[i] <= stage_valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      stage_data_q[0] <= mac_d;
    end
    for (int i = 1; i <= NumPipeRegs; i++) begin
      stage_data_q[i] <= stage_data_q[i-1];
    end
  end

  assign z_push_o = stage_valid_q[NumPipeRegs];
  assign z_col_o  = stage_data_q[NumPipeRegs];

endmodule : redmule_engine

//--- design/redmule_z_fifo.sv
`timescale 1ns/10ps

module redmule_z_fifo #(
  parameter int unsigned Width      = 4,
  parameter int unsigned ZFifoDepth = 4
)(
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      push_i,
  input  logic [Width-1:0][redmule_pkg::ELEM_W-1:0] data_i,
  input  logic                                      ready_i,
  output logic                                      valid_o,
  output logic [Width-1:0][redmule_pkg::ELEM_W-1:0] data_o
);

  localparam int unsigned PtrW = (ZFifoDepth > 1) ? $clog2(ZFifoDepth) : 1;
  localparam int unsigned CntW = $clog2(ZFifoDepth + 1);

  logic [Width-1:0][redmule_pkg::ELEM_W-1:0] mem_q [ZFifoDepth];
  logic [PtrW-1:0]                           wr_ptr_q;
  logic [PtrW-1:0]                           rd_ptr_q;
  logic [CntW-1:0]                           count_q;
  logic                                      pop;

  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at the last entry, depth need not be a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(ZFifoDepth - 1)) ? '0 : wr_ptr_q + PtrW'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(ZFifoDepth - 1)) ? '0 : rd_ptr_q + PtrW'(1);
      end
      if (push_i && !pop) begin
        count_q <= count_q + CntW'(1);
      end else if (pop && !push_i) begin
        count_q <= count_q - CntW'(1);
      end
    end
  end

endmodule : redmule_z_fifo

//--- design/redmule_top.sv
`timescale 1ns/10ps

module redmule_top #(
  parameter int unsigned Width       = 4,
  parameter int unsigned Height      = 4,
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned ZFifoDepth  = 4
)(
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          start_i,
  input  logic [redmule_pkg::COUNT_W-1:0]               n_cols_i,
  output logic                                          busy_o,
  output logic                                          done_o,
  input  logic                                          x_valid_i,
  input  logic [Height-1:0][redmule_pkg::ELEM_W-1:0]    x_data_i,
  output logic                                          x_ready_o,
  input  logic                                          w_valid_i,
  input  logic [Height-1:0][redmule_pkg::ELEM_W-1:0]    w_data_i,
  output logic                                          w_ready_o,
  input  logic                                          y_valid_i,
  input  logic [Width-1:0][redmule_pkg::ELEM_W-1:0]     y_data_i,
  output logic                                          y_ready_o,
  output logic                                          z_valid_o,
  output logic [Width-1:0][redmule_pkg::ELEM_W-1:0]     z_data_o,
  input  logic                                          z_ready_i
);

  logic                                                x_load;
  logic                                                x_full;
  logic [Width-1:0][Height-1:0][redmule_pkg::ELEM_W-1:0] x_tile;
  logic                                                issue;
  logic                                                z_push;
  logic [Width-1:0][redmule_pkg::ELEM_W-1:0]           z_col;
  logic                                                z_pop;

  // An accepted Z beat hands a credit back to the scheduler
  assign z_pop = z_valid_o && z_ready_i;

  // W and Y are always taken as one pair
  assign x_ready_o = x_load;
  assign w_ready_o = issue;
  assign y_ready_o = issue;

  redmule_scheduler #(
    .Width      ( Width      ),
    .ZFifoDepth ( ZFifoDepth )
  ) i_scheduler (
    .clk_i     ( clk_i     ),
    .reset_i   ( reset_i   ),
    .start_i   ( start_i   ),
    .n_cols_i  ( n_cols_i  ),
    .x_valid_i ( x_valid_i ),
    .x_full_i  ( x_full    ),
    .w_valid_i ( w_valid_i ),
    .y_valid_i ( y_valid_i ),
    .z_pop_i   ( z_pop     ),
    .x_load_o  ( x_load    ),
    .issue_o   ( issue     ),
    .busy_o    ( busy_o    ),
    .done_o    ( done_o    )
  );

  redmule_x_buffer #(
    .Width  ( Width  ),
    .Height ( Height )
  ) i_x_buffer (
    .clk_i    ( clk_i    ),
    .reset_i  ( reset_i  ),
    .start_i  ( start_i  ),
    .load_i   ( x_load   ),
    .row_i    ( x_data_i ),
    .x_tile_o ( x_tile   ),
    .full_o   ( x_full   )
  );

  redmule_engine #(
    .Width       ( Width       ),
    .Height      ( Height      ),
    .NumPipeRegs ( NumPipeRegs )
  ) i_engine (
    .clk_i    ( clk_i    ),
    .reset_i  ( reset_i  ),
    .issue_i  ( issue    ),
    .x_tile_i ( x_tile   ),
    .w_col_i  ( w_data_i ),
    .y_col_i  ( y_data_i ),
    .z_push_o ( z_push   ),
    .z_col_o  ( z_col    )
  );

  redmule_z_fifo #(
    .Width      ( Width      ),
    .ZFifoDepth ( ZFifoDepth )
  ) i_z_fifo (
    .clk_i   ( clk_i     ),
    .reset_i ( reset_i   ),
    .push_i  ( z_push    ),
    .data_i  ( z_col     ),
    .ready_i ( z_ready_i ),
    .valid_o ( z_valid_o ),
    .data_o  ( z_data_o  )
  );

endmodule : redmule_top

//--- verification/redmule_tb.sv
`timescale 1ns/10ps

module redmule_tb;

  localparam int unsigned Width       = 4;
  localparam int unsigned Height      = 4;
  localparam int unsigned NumPipeRegs = 2;
  localparam int unsigned ZFifoDepth  = 4;
  localparam int unsigned ElemW       = redmule_pkg::ELEM_W;
  localparam int unsigned ResetCycles = 10;
  localparam int unsigned NumJobs     = 4;
  // Worst case per job: X load, every column stalled, pipeline and slack
  localparam int unsigned WatchdogCycles =
    NumJobs * (Width + 255 * 4 + NumPipeRegs + 20) + ResetCycles;

  typedef logic [Width-1:0][ElemW-1:0] zcol_t;
  typedef logic [Height-1:0][ElemW-1:0] wcol_t;
  typedef logic [Width-1:0][Height-1:0][ElemW-1:0] tile_t;

  logic clk_i, reset_i, start_i, busy_o, done_o;
  logic [redmule_pkg::COUNT_W-1:0] n_cols_i;
  logic x_valid_i, x_ready_o, w_valid_i, w_ready_o, y_valid_i, y_ready_o;
  logic z_valid_o, z_ready_i;
  wcol_t x_data_i, w_data_i;
  zcol_t y_data_i, z_data_o;

  // Reference model state, captured from accepted beats
  tile_t       tile_m;
  zcol_t       exp_q[$];
  int unsigned n_cols_m, x_rows, pairs, pops;
  int unsigned data_errs = 0;
  int unsigned proto_errs = 0;
  string       test_name = "reset";
  logic        done_seen = 1'b0;
  logic        reset_q = 1'b0;
  logic        start_acc_q = 1'b0;
  logic        done_q = 1'b0;
  logic        last_pop_q = 1'b0;
  logic        zv_q = 1'b0;
  logic        zr_q = 1'b0;
  zcol_t       zd_q;

  redmule_top #(
    .Width       ( Width       ),
    .Height      ( Height      ),
    .NumPipeRegs ( NumPipeRegs ),
    .ZFifoDepth  ( ZFifoDepth  )
  ) UUT (
    .clk_i     ( clk_i     ), .reset_i   ( reset_i   ), .start_i   ( start_i   ),
    .n_cols_i  ( n_cols_i  ), .busy_o    ( busy_o    ), .done_o    ( done_o    ),
    .x_valid_i ( x_valid_i ), .x_data_i  ( x_data_i  ), .x_ready_o ( x_ready_o ),
    .w_valid_i ( w_valid_i ), .w_data_i  ( w_data_i  ), .w_ready_o ( w_ready_o ),
    .y_valid_i ( y_valid_i ), .y_data_i  ( y_data_i  ), .y_ready_o ( y_ready_o ),
    .z_valid_o ( z_valid_o ), .z_data_o  ( z_data_o  ), .z_ready_i ( z_ready_i )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Z[r] = Y[r] + sum over h of X[r][h] * W[h], kept modulo 2**ELEM_W
  function automatic zcol_t model_z(input tile_t x, input wcol_t w, input zcol_t y);
    zcol_t       z;
    logic [63:0] sum;
    for (int r = 0; r < Width; r++) begin
      sum = 64'(y[r]);
      for (int h = 0; h < Height; h++) begin
        sum = sum + 64'(x[r][h]) * 64'(w[h]);
      end
      z[r] = sum[ElemW-1:0];
    end
    return z;
  endfunction

  function automatic logic [ElemW-1:0] rand_elem(input bit max_data);
    return max_data ? '1 : ElemW'($urandom);
  endfunction

  task automatic flag_protocol_error(input string msg);
    proto_errs++;
    $display("Protocol error in %s at %0t: %s", test_name, $time, msg);
  endtask

  task automatic flag_mismatch(input string what, input zcol_t exp_v, input zcol_t act_v);
    data_errs++;
    $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
  endtask

  always @(posedge clk_i) begin : monitor
    zcol_t exp_z;
    if (reset_q) begin
      assert (!busy_o && !done_o && !x_ready_o && !w_ready_o && !y_ready_o && !z_valid_o)
        else flag_protocol_error("an output is not low during or right after reset");
    end
    if (reset_i) begin
      exp_q.delete();
      start_acc_q = 1'b0;
      done_q      = 1'b0;
      last_pop_q  = 1'b0;
    end else begin
      assert (w_ready_o == y_ready_o) else flag_protocol_error("w_ready_o and y_ready_o differ");
      if (start_acc_q) begin
        assert (busy_o) else flag_protocol_error("busy_o did not rise after an accepted start");
      end
      if (done_q) begin
        assert (!busy_o) else flag_protocol_error("busy_o stayed high after the done pulse");
      end
      if (done_o) begin
        assert (busy_o) else flag_protocol_error("busy_o was low in the done cycle");
      end
      assert (done_o == last_pop_q)
        else flag_protocol_error("done_o did not pulse exactly once after the last Z beat");
      if (zv_q && !zr_q) begin
        assert (z_valid_o && z_data_o == zd_q)
          else flag_protocol_error("Z beat changed while z_ready_i was low");
      end
      if (x_valid_i && x_ready_o) begin
        assert (x_rows < Width) else flag_protocol_error("more X rows accepted than the tile holds");
        tile_m[x_rows] = x_data_i;
        x_rows++;
      end
      if (w_ready_o) begin
        assert (w_valid_i && y_valid_i) else flag_protocol_error("W/Y ready without both valids");
        assert (pairs < n_cols_m) else flag_protocol_error("more W/Y pairs accepted than n_cols");
        pairs++;
        exp_q.push_back(model_z(tile_m, w_data_i, y_data_i));
      end
      last_pop_q = 1'b0;
      if (z_valid_o && z_ready_i) begin
        if (exp_q.size() == 0) begin
          flag_protocol_error("Z beat arrived with no column outstanding");
        end else begin
          exp_z = exp_q.pop_front();
          assert (z_data_o == exp_z) else flag_mismatch("Z column", exp_z, z_data_o);
        end
        pops++;
        last_pop_q = (pops == n_cols_m);
      end
      start_acc_q = start_i && !busy_o;
      if (start_acc_q) begin
        n_cols_m = n_cols_i;
        x_rows   = 0;
        pairs    = 0;
        pops     = 0;
      end
      done_q = done_o;
      if (done_o) begin
        done_seen = 1'b1;
      end
    end
    reset_q = reset_i;
    zv_q    = z_valid_o;
    zr_q    = z_ready_i;
    zd_q    = z_data_o;
  end

  task automatic set_x_row(input bit max_data);
    for (int h = 0; h < Height; h++) begin
      x_data_i[h] = rand_elem(max_data);
    end
  endtask

  task automatic set_wy_pair(input bit max_data);
    for (int h = 0; h < Height; h++) begin
      w_data_i[h] = rand_elem(max_data);
    end
    for (int r = 0; r < Width; r++) begin
      y_data_i[r] = rand_elem(max_data);
    end
  endtask

  task automatic drive_x(input int unsigned gap_pct, input bit max_data, input bit offer_next,
                         input bit next_max);
    for (int r = 0; r < Width; r++) begin
      // A row left on offer by the previous job is taken as it stands
      if (!x_valid_i) begin
        while (($urandom % 100) < gap_pct) @(negedge clk_i);
        set_x_row(max_data);
        x_valid_i = 1'b1;
      end
      @(posedge clk_i);
      while (!x_ready_o) @(posedge clk_i);
      @(negedge clk_i);
      x_valid_i = 1'b0;
    end
    // The next job's first row waits on the bus through the rest of this job
    if (offer_next) begin
      set_x_row(next_max);
      x_valid_i = 1'b1;
    end
  endtask

  // W and Y go out as one pair, now and then with one half raised a cycle early
  task automatic drive_wy(input int unsigned ncols, input int unsigned gap_pct,
                          input bit max_data, input bit offer_next, input bit next_max);
    for (int c = 0; c < ncols; c++) begin
      if (!(w_valid_i && y_valid_i)) begin
        while (($urandom % 100) < gap_pct) @(negedge clk_i);
        set_wy_pair(max_data);
        if (gap_pct != 0 && ($urandom % 4) == 0) begin
          if ($urandom % 2) begin
            w_valid_i = 1'b1;
          end else begin
            y_valid_i = 1'b1;
          end
          @(negedge clk_i);
        end
        w_valid_i = 1'b1;
        y_valid_i = 1'b1;
      end
      @(posedge clk_i);
      while (!w_ready_o) @(posedge clk_i);
      @(negedge clk_i);
      w_valid_i = 1'b0;
      y_valid_i = 1'b0;
    end
    // One pair beyond n_cols stays offered until the next job takes it
    if (offer_next) begin
      set_wy_pair(next_max);
      w_valid_i = 1'b1;
      y_valid_i = 1'b1;
    end
  endtask

  task automatic drive_z_ready(input int unsigned stall_pct);
    while (!done_seen) begin
      z_ready_i = (($urandom % 100) >= stall_pct);
      @(negedge clk_i);
    end
    z_ready_i = 1'b1;
  endtask

  task automatic pulse_start_while_busy();
    repeat (Width + 3) @(negedge clk_i);
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
  endtask

  task automatic run_job(input string name, input int unsigned ncols, input int unsigned gap_pct,
                         input int unsigned stall_pct, input bit max_data, input bit extra_start,
                         input bit offer_next, input bit next_max);
    test_name = name;
    done_seen = 1'b0;
    n_cols_i  = redmule_pkg::COUNT_W'(ncols);
    start_i   = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    fork
      drive_x(gap_pct, max_data, offer_next, next_max);
      drive_wy(ncols, gap_pct, max_data, offer_next, next_max);
      drive_z_ready(stall_pct);
      if (extra_start) pulse_start_while_busy();
    join
    @(negedge clk_i);
    // Lost or duplicated Z beats show up as a count mismatch
    assert (pops == ncols && exp_q.size() == 0)
      else flag_mismatch("Z beat count", zcol_t'(ncols), zcol_t'(pops));
  endtask

  initial begin
    void'($urandom(32'h83e2));
    reset_i   = 1'b1;
    start_i   = 1'b0;
    n_cols_i  = '0;
    x_valid_i = 1'b0;
    x_data_i  = '0;
    w_valid_i = 1'b0;
    w_data_i  = '0;
    y_valid_i = 1'b0;
    y_data_i  = '0;
    z_ready_i = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    repeat (2) @(negedge clk_i);
    run_job("single_col", 1, 0, 0, 1'b0, 1'b0, 1'b1, 1'b0);
    run_job("five_cols", 5, 0, 0, 1'b0, 1'b0, 1'b1, 1'b0);
    run_job("gaps_backpressure", 40, 30, 40, 1'b0, 1'b1, 1'b1, 1'b1);
    run_job("wrap_max", 3, 0, 0, 1'b1, 1'b0, 1'b0, 1'b0);
    repeat (4) @(negedge clk_i);
    $display("Errors: %0d data, %0d protocol", data_errs, proto_errs);
    if (data_errs == 0 && proto_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Timeout in %s: the run did not finish within %0d cycles", test_name,
             WatchdogCycles);
    $display("Errors: %0d data, %0d protocol", data_errs, proto_errs);
    $display("test failed");
    $finish;
  end

endmodule : redmule_tb

//--- all.f
design/redmule_pkg.sv
design/redmule_scheduler.sv
design/redmule_x_buffer.sv
design/redmule_engine.sv
design/redmule_z_fifo.sv
design/redmule_top.sv
verification/redmule_tb.sv
